/* logic/tuner_defs.svh */
`ifndef TUNER_DEFS_SVH
`define TUNER_DEFS_SVH

// ----------------------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------------------
// Ring heater DAC code
`define TUNER_DAC_WIDTH 8
// Power detector reading
`define TUNER_ADC_WIDTH 8

// ----------------------------------------------------------------------
// Peak detection
// ----------------------------------------------------------------------
// Half window, full window is 2*H+1 samples
`define TUNER_PEAK_HALF 4
// Trend votes needed on each side of the centre
`define TUNER_VOTE_THRES 2
// Evaluations skipped once a peak is seen
`define TUNER_PEAK_HOLDOFF 7
// Result slots
`define TUNER_NUM_PEAKS 8

`endif

/* logic/tuner_data_pkg.sv */
`include "tuner_defs.svh"

package tuner_data_pkg;

  // DAC tune code sent to the ring heater
  typedef logic [`TUNER_DAC_WIDTH-1:0] tune_code_t;

  // Committed power reading
  typedef logic [`TUNER_ADC_WIDTH-1:0] pwr_t;

  // Log2 of the sweep step
  typedef logic [$clog2(`TUNER_DAC_WIDTH)-1:0] stride_t;

  // Number of stored peaks, 0 up to full
  typedef logic [$clog2(`TUNER_NUM_PEAKS+1)-1:0] peak_cnt_t;

endpackage

/* logic/tuner_ctrl_pkg.sv */
package tuner_ctrl_pkg;

  // Top level search flow
  typedef enum logic [1:0] {
    SEARCH_IDLE,
    SEARCH_INIT,
    SEARCH_ACTIVE,
    SEARCH_DONE
  } search_state_e;

  // Sub-phase inside SEARCH_ACTIVE
  // Tune hands a code out, update waits for its power
  typedef enum logic {
    CTRL_TUNE,
    CTRL_UPDATE
  } ctrl_phase_e;

endpackage

/* logic/search_sequencer.sv */
`timescale 1ns/1ps

module search_sequencer
  import tuner_data_pkg::*;
  import tuner_ctrl_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  input  tune_code_t i_tune_start,
  input  tune_code_t i_tune_end,
  input  stride_t    i_tune_stride,
  input  logic       i_trig_val,
  input  logic       i_tune_rdy,
  input  logic       i_commit_val,
  input  pwr_t       i_pwr_commit,
  input  logic       i_peaks_rdy,
  output logic       o_trig_rdy,
  output logic       o_peaks_val,
  output logic       o_peaks_fire,
  output logic       o_tune_val,
  output tune_code_t o_ring_tune,
  output logic       o_commit_rdy,
  output logic       o_refresh,
  output logic       o_update,
  output pwr_t       o_sample_pwr,
  output tune_code_t o_sample_code
);

  search_state_e state, state_next;
  ctrl_phase_e   phase, phase_next;

  logic       trig_fire;
  logic       tune_fire;
  logic       commit_fire;
  logic       is_active;
  logic       is_tune;
  logic       is_update;
  logic       compute_done;
  logic       sweep_left;
  logic       active_done;
  // Commit history, covers the window and store pipeline
  logic [1:0] update_hist;
  tune_code_t ring_tune;
  tune_code_t tune_step;
  tune_code_t sweep_cnt;
  tune_code_t sweep_max;

  // ----------------------------------------------------------------------
  // Handshakes
  // ----------------------------------------------------------------------
  assign o_trig_rdy   = (state == SEARCH_IDLE) || (state == SEARCH_DONE);
  assign o_peaks_val  = (state == SEARCH_DONE);
  assign trig_fire    = o_trig_rdy && i_trig_val;
  assign o_peaks_fire = o_peaks_val && i_peaks_rdy;

  // Single cycle clear of everything downstream
  assign o_refresh = (state == SEARCH_INIT);

  assign is_active = (state == SEARCH_ACTIVE);
  assign is_tune   = is_active && (phase == CTRL_TUNE);
  assign is_update = is_active && (phase == CTRL_UPDATE);

  // No new code once all N commits are in
  assign o_tune_val   = is_tune && compute_done && sweep_left;
  assign tune_fire    = o_tune_val && i_tune_rdy;
  assign o_commit_rdy = is_update;
  assign commit_fire  = o_commit_rdy && i_commit_val;
  assign o_update     = commit_fire;

  // ----------------------------------------------------------------------
  // Search FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      state <= SEARCH_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      SEARCH_IDLE:   if (trig_fire) state_next = SEARCH_INIT;
      SEARCH_INIT:   state_next = SEARCH_ACTIVE;
      SEARCH_ACTIVE: if (active_done) state_next = SEARCH_DONE;
      // Re-trigger starts a fresh sweep
      SEARCH_DONE:   if (trig_fire) state_next = SEARCH_INIT;
      default:       state_next = SEARCH_IDLE;
    endcase
  end

  // ----------------------------------------------------------------------
  // Tune / update phase
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      phase <= CTRL_TUNE;
    end else if (o_refresh) begin
      phase <= CTRL_TUNE;
    end else begin
      phase <= phase_next;
    end
  end

  always_comb begin
    phase_next = phase;
    if (is_active) begin
      case (phase)
        CTRL_TUNE:   if (tune_fire) phase_next = CTRL_UPDATE;
        CTRL_UPDATE: if (commit_fire) phase_next = CTRL_TUNE;
        default:     phase_next = CTRL_TUNE;
      endcase
    end
  end

  // One compute cycle on each entry to tune
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      compute_done <= 1'b0;
    end else if (o_refresh) begin
      compute_done <= 1'b0;
    end else if (is_tune) begin
      compute_done <= 1'b1;
    end else if (is_update) begin
      compute_done <= 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // Code stepping and sweep count
  // ----------------------------------------------------------------------
  assign tune_step   = tune_code_t'(1) << i_tune_stride;
  assign sweep_max   = (i_tune_end - i_tune_start) >> i_tune_stride;
  assign sweep_left  = (sweep_cnt < sweep_max);
  // Wait for the last sample to reach the store
  assign active_done = !sweep_left && (update_hist == 2'b00);
  assign o_ring_tune = ring_tune;

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      ring_tune   <= '0;
      sweep_cnt   <= '0;
      update_hist <= '0;
    end else if (o_refresh) begin
      ring_tune   <= i_tune_start;
      sweep_cnt   <= '0;
      update_hist <= '0;
    end else begin
      update_hist <= {update_hist[0], o_update};
      // Step after the power of the current code is in
      if (commit_fire) begin
        ring_tune <= ring_tune + tune_step;
        sweep_cnt <= sweep_cnt + 1'b1;
      end
    end
  end

  // Power and the code it was measured at
  always_ff @(posedge i_clk) begin
    if (commit_fire) begin
      o_sample_pwr  <= i_pwr_commit;
      o_sample_code <= ring_tune;
    end
  end

endmodule

/* logic/peak_window.sv */
`timescale 1ns/1ps
`include "tuner_defs.svh"

module peak_window
  import tuner_data_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_refresh,
  input  logic       i_update,
  input  pwr_t       i_sample_pwr,
  input  tune_code_t i_sample_code,
  output logic       o_peak_commit,
  output tune_code_t o_peak_code,
  output pwr_t       o_peak_pwr
);

  localparam int HALF       = `TUNER_PEAK_HALF;
  localparam int WIN_SIZE   = 2 * HALF + 1;
  localparam int FILL_WIDTH = $clog2(WIN_SIZE + 1);
  localparam int HOLD_WIDTH = $clog2(`TUNER_PEAK_HOLDOFF + 1);

  // Index 0 is the newest sample, HALF is the centre
  tune_code_t code_win [WIN_SIZE];
  pwr_t       pwr_win  [WIN_SIZE];
  // Flag i compares sample i against sample i+1
  logic [2*HALF-1:0] rise_win;
  logic [2*HALF-1:0] fall_win;

  logic                  shift_en;
  logic                  eval_en;
  logic [FILL_WIDTH-1:0] fill_cnt;
  logic [HOLD_WIDTH-1:0] holdoff_cnt;
  logic                  rise_vote;
  logic                  fall_vote;
  logic                  peak_found;
  logic                  warmed_up;

  function automatic logic vote_ok(input logic [HALF-1:0] votes);
    int sum;
    sum = 0;
    for (int i = 0; i < HALF; i++) begin
      sum += int'(votes[i]);
    end
    return (sum >= `TUNER_VOTE_THRES);
  endfunction

  // ----------------------------------------------------------------------
  // Pipeline strobes
  // ----------------------------------------------------------------------
  // Shift one cycle after the commit, evaluate the cycle after
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      shift_en <= 1'b0;
      eval_en  <= 1'b0;
    end else if (i_refresh) begin
      shift_en <= 1'b0;
      eval_en  <= 1'b0;
    end else begin
      shift_en <= i_update;
      eval_en  <= shift_en;
    end
  end

  // ----------------------------------------------------------------------
  // Sample window
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_refresh) begin
      for (int i = 0; i < WIN_SIZE; i++) begin
        code_win[i] <= '0;
        pwr_win[i]  <= '0;
      end
    end else if (shift_en) begin
      code_win[0] <= i_sample_code;
      pwr_win[0]  <= i_sample_pwr;
      for (int i = 1; i < WIN_SIZE; i++) begin
        code_win[i] <= code_win[i-1];
        pwr_win[i]  <= pwr_win[i-1];
      end
    end
  end

  // Trend of the new sample against the previous one
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      rise_win <= '0;
      fall_win <= '0;
    end else if (i_refresh) begin
      rise_win <= '0;
      fall_win <= '0;
    end else if (shift_en) begin
      rise_win <= {rise_win[2*HALF-2:0], (i_sample_pwr > pwr_win[0])};
      fall_win <= {fall_win[2*HALF-2:0], (i_sample_pwr < pwr_win[0])};
    end
  end

  // ----------------------------------------------------------------------
  // Vote and invalidation
  // ----------------------------------------------------------------------
  // Rising into the centre, falling out of it
  assign rise_vote  = vote_ok(rise_win[2*HALF-1:HALF]);
  assign fall_vote  = vote_ok(fall_win[HALF-1:0]);
  assign peak_found = rise_vote && fall_vote;
  assign warmed_up  = (fill_cnt == FILL_WIDTH'(WIN_SIZE));

  // Samples seen since refresh, saturating at a full window
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      fill_cnt <= '0;
    end else if (i_refresh) begin
      fill_cnt <= '0;
    end else if (shift_en && !warmed_up) begin
      fill_cnt <= fill_cnt + 1'b1;
    end
  end

  // Neighbours of a peak also win the vote
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      holdoff_cnt <= '0;
    end else if (i_refresh) begin
      holdoff_cnt <= '0;
    end else if (eval_en) begin
      if (holdoff_cnt != '0) begin
        holdoff_cnt <= holdoff_cnt - 1'b1;
      end else if (peak_found) begin
        holdoff_cnt <= HOLD_WIDTH'(`TUNER_PEAK_HOLDOFF);
      end
    end
  end

  assign o_peak_commit = eval_en && peak_found && warmed_up && (holdoff_cnt == '0);
  assign o_peak_code   = code_win[HALF];
  assign o_peak_pwr    = pwr_win[HALF];

endmodule

/* logic/peak_store.sv */
`timescale 1ns/1ps
`include "tuner_defs.svh"

module peak_store
  import tuner_data_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_refresh,
  input  logic       i_peak_commit,
  input  tune_code_t i_peak_code,
  input  pwr_t       i_peak_pwr,
  input  logic       i_peaks_fire,
  output tune_code_t o_peak_tune [`TUNER_NUM_PEAKS],
  output pwr_t       o_peak_pwr  [`TUNER_NUM_PEAKS],
  output peak_cnt_t  o_peak_cnt
);

  localparam int IDX_WIDTH = $clog2(`TUNER_NUM_PEAKS);

  tune_code_t tune_q [`TUNER_NUM_PEAKS];
  pwr_t       pwr_q  [`TUNER_NUM_PEAKS];
  peak_cnt_t  cnt_q;
  logic       store_full;
  logic       store_wr;

  // Extra peaks past capacity are dropped
  assign store_full = (cnt_q == peak_cnt_t'(`TUNER_NUM_PEAKS));
  assign store_wr   = i_peak_commit && !store_full;

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      cnt_q <= '0;
    end else if (i_refresh) begin
      cnt_q <= '0;
    end else if (store_wr) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Peaks fill in sweep order
  always_ff @(posedge i_clk) begin
    if (i_refresh) begin
      for (int i = 0; i < `TUNER_NUM_PEAKS; i++) begin
        tune_q[i] <= '0;
        pwr_q[i]  <= '0;
      end
    end else if (store_wr) begin
      tune_q[cnt_q[IDX_WIDTH-1:0]] <= i_peak_code;
      pwr_q[cnt_q[IDX_WIDTH-1:0]]  <= i_peak_pwr;
    end
  end

  // Results only visible during the results fire
  always_comb begin
    for (int i = 0; i < `TUNER_NUM_PEAKS; i++) begin
      o_peak_tune[i] = i_peaks_fire ? tune_q[i] : '0;
      o_peak_pwr[i]  = i_peaks_fire ? pwr_q[i] : '0;
    end
    o_peak_cnt = i_peaks_fire ? cnt_q : '0;
  end

endmodule

/* logic/tuner_search_top.sv */
`timescale 1ns/1ps
`include "tuner_defs.svh"

module tuner_search_top
  import tuner_data_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  // Sweep configuration
  input  tune_code_t i_tune_start,
  input  tune_code_t i_tune_end,
  input  stride_t    i_tune_stride,
  // Trigger
  input  logic       i_trig_val,
  output logic       o_trig_rdy,
  // Results
  output logic       o_peaks_val,
  input  logic       i_peaks_rdy,
  output tune_code_t o_peak_tune [`TUNER_NUM_PEAKS],
  output pwr_t       o_peak_pwr  [`TUNER_NUM_PEAKS],
  output peak_cnt_t  o_peak_cnt,
  // Ring tune to the AFE
  output logic       o_tune_val,
  output tune_code_t o_ring_tune,
  input  logic       i_tune_rdy,
  // Power commit from the AFE
  output logic       o_commit_rdy,
  input  logic       i_commit_val,
  input  pwr_t       i_pwr_commit
);

  logic       peaks_fire;
  logic       refresh;
  logic       update;
  pwr_t       sample_pwr;
  tune_code_t sample_code;
  logic       peak_commit;
  tune_code_t peak_code;
  pwr_t       peak_pwr;

  search_sequencer search_sequencer_inst (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_tune_start  (i_tune_start),
    .i_tune_end    (i_tune_end),
    .i_tune_stride (i_tune_stride),
    .i_trig_val    (i_trig_val),
    .i_tune_rdy    (i_tune_rdy),
    .i_commit_val  (i_commit_val),
    .i_pwr_commit  (i_pwr_commit),
    .i_peaks_rdy   (i_peaks_rdy),
    .o_trig_rdy    (o_trig_rdy),
    .o_peaks_val   (o_peaks_val),
    .o_peaks_fire  (peaks_fire),
    .o_tune_val    (o_tune_val),
    .o_ring_tune   (o_ring_tune),
    .o_commit_rdy  (o_commit_rdy),
    .o_refresh     (refresh),
    .o_update      (update),
    .o_sample_pwr  (sample_pwr),
    .o_sample_code (sample_code)
  );

  peak_window peak_window_inst (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_refresh     (refresh),
    .i_update      (update),
    .i_sample_pwr  (sample_pwr),
    .i_sample_code (sample_code),
    .o_peak_commit (peak_commit),
    .o_peak_code   (peak_code),
    .o_peak_pwr    (peak_pwr)
  );

  peak_store peak_store_inst (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_refresh     (refresh),
    .i_peak_commit (peak_commit),
    .i_peak_code   (peak_code),
    .i_peak_pwr    (peak_pwr),
    .i_peaks_fire  (peaks_fire),
    .o_peak_tune   (o_peak_tune),
    .o_peak_pwr    (o_peak_pwr),
    .o_peak_cnt    (o_peak_cnt)
  );

endmodule

/* sim/tb_tuner_search.sv */
`timescale 1ns/1ps
`include "tuner_defs.svh"

module tb_tuner_search
  import tuner_data_pkg::*;
();

  localparam int NUM_CASES = 8;
  localparam int CASE_COLS = 8;
  localparam int CLK_NS    = 20;
  localparam int NPK       = `TUNER_NUM_PEAKS;

  logic       i_clk = 1'b0;
  logic       i_rst;
  tune_code_t i_tune_start;
  tune_code_t i_tune_end;
  stride_t    i_tune_stride;
  logic       i_trig_val;
  logic       i_peaks_rdy;
  logic       i_tune_rdy;
  logic       i_commit_val;
  pwr_t       i_pwr_commit;
  logic       o_trig_rdy;
  logic       o_peaks_val;
  logic       o_tune_val;
  logic       o_commit_rdy;
  tune_code_t o_ring_tune;
  tune_code_t o_peak_tune [NPK];
  pwr_t       o_peak_pwr  [NPK];
  peak_cnt_t  o_peak_cnt;

  // Eight columns per sweep in the order of the case file
  logic [7:0] case_mem [NUM_CASES*CASE_COLS];
  int         seed;
  int         err_cnt;
  int         check_cnt;
  // Expected peaks of the running sweep
  int         exp_cnt;
  int         exp_code [NPK];
  int         exp_pwr  [NPK];
  longint     wd_cycles;
  bit         wd_armed = 1'b0;

  always #(CLK_NS/2) i_clk = ~i_clk;

  tuner_search_top tuner_search_top_inst (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_tune_start  (i_tune_start),
    .i_tune_end    (i_tune_end),
    .i_tune_stride (i_tune_stride),
    .i_trig_val    (i_trig_val),
    .o_trig_rdy    (o_trig_rdy),
    .o_peaks_val   (o_peaks_val),
    .i_peaks_rdy   (i_peaks_rdy),
    .o_peak_tune   (o_peak_tune),
    .o_peak_pwr    (o_peak_pwr),
    .o_peak_cnt    (o_peak_cnt),
    .o_tune_val    (o_tune_val),
    .o_ring_tune   (o_ring_tune),
    .i_tune_rdy    (i_tune_rdy),
    .o_commit_rdy  (o_commit_rdy),
    .i_commit_val  (i_commit_val),
    .i_pwr_commit  (i_pwr_commit)
  );

  // ----------------------------------------------------------------------
  // Case fields and power profile
  // ----------------------------------------------------------------------
  function automatic int field(input int idx, input int col);
    return int'(case_mem[idx*CASE_COLS+col]);
  endfunction

  // Number of commits for a sweep
  function automatic int sweep_len(input int idx);
    return ((field(idx, 1) - field(idx, 0)) & 255) >> field(idx, 2);
  endfunction

  // Code handed out at a given step of the sweep
  function automatic int expected_code(input int idx, input int cnt);
    return (field(idx, 0) + (cnt << field(idx, 2))) & 255;
  endfunction

  // One triangle that repeats every period codes when period is set
  function automatic int tri_height(input int idx, input int code, input int centre);
    int d;
    int v;
    d = (code > centre) ? code - centre : centre - code;
    if (field(idx, 7) != 0) begin
      d = d % field(idx, 7);
      if (field(idx, 7) - d < d) d = field(idx, 7) - d;
    end
    v = field(idx, 5) - field(idx, 6) * d;
    return (v < 0) ? 0 : v;
  endfunction

  function automatic int profile_power(input int idx, input int code);
    int a;
    int b;
    a = tri_height(idx, code, field(idx, 3));
    b = tri_height(idx, code, field(idx, 4));
    return (a > b) ? a : b;
  endfunction

  // ----------------------------------------------------------------------
  // Reference peak search
  // ----------------------------------------------------------------------
  task automatic build_model(input int idx, input int n);
    int  p [256];
    bit  rise [256];
    bit  fall [256];
    int  prev;
    int  rise_n;
    int  fall_n;
    int  hold;
    int  step;
    step    = 1 << field(idx, 2);
    exp_cnt = 0;
    hold    = 0;
    for (int i = 0; i < NPK; i++) begin
      exp_code[i] = 0;
      exp_pwr[i]  = 0;
    end
    // Cleared window reads as zero power before the first sample
    for (int k = 0; k < n; k++) begin
      p[k]    = profile_power(idx, (field(idx, 0) + k * step) & 255);
      prev    = (k == 0) ? 0 : p[k-1];
      rise[k] = p[k] > prev;
      fall[k] = p[k] < prev;
    end
    for (int k = 0; k < n; k++) begin
      rise_n = 0;
      fall_n = 0;
      // Falls after the centre and rises leading into it
      for (int j = 0; j < `TUNER_PEAK_HALF; j++) begin
        if (k - j >= 0 && fall[k-j]) fall_n++;
        if (k - j - `TUNER_PEAK_HALF >= 0 && rise[k-j-`TUNER_PEAK_HALF]) rise_n++;
      end
      if (hold != 0) begin
        hold--;
      end else if (rise_n >= `TUNER_VOTE_THRES && fall_n >= `TUNER_VOTE_THRES) begin
        hold = `TUNER_PEAK_HOLDOFF;
        if (k + 1 >= 2 * `TUNER_PEAK_HALF + 1 && exp_cnt < NPK) begin
          exp_code[exp_cnt] = (field(idx, 0) + (k - `TUNER_PEAK_HALF) * step) & 255;
          exp_pwr[exp_cnt]  = p[k-`TUNER_PEAK_HALF];
          exp_cnt++;
        end
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  task automatic check_value(input string name, input int got, input int exp);
    check_cnt++;
    assert (got == exp) else begin
      $display("[FAIL] %0t ns %s expected %0d actual %0d", $time, name, exp, got);
      err_cnt++;
    end
  endtask

  // Results match the model during the fire and read zero otherwise
  task automatic check_results(input bit at_fire);
    check_value("o_peak_cnt", int'(o_peak_cnt), at_fire ? exp_cnt : 0);
    for (int i = 0; i < NPK; i++) begin
      check_value($sformatf("o_peak_tune[%0d]", i), int'(o_peak_tune[i]),
                  at_fire ? exp_code[i] : 0);
      check_value($sformatf("o_peak_pwr[%0d]", i), int'(o_peak_pwr[i]),
                  at_fire ? exp_pwr[i] : 0);
    end
  endtask

  // ----------------------------------------------------------------------
  // One sweep with the AFE responder
  // ----------------------------------------------------------------------
  task automatic run_sweep(input int idx);
    int n;
    int tune_cnt;
    int commit_cnt;
    int tune_dly;
    int cmt_dly;
    int last_code;
    int errs_before;
    bit done;
    n           = sweep_len(idx);
    errs_before = err_cnt;
    tune_cnt    = 0;
    commit_cnt  = 0;
    tune_dly    = -1;
    cmt_dly     = -1;
    last_code   = 0;
    done        = 1'b0;
    build_model(idx, n);
    i_tune_start  <= tune_code_t'(field(idx, 0));
    i_tune_end    <= tune_code_t'(field(idx, 1));
    i_tune_stride <= stride_t'(field(idx, 2));
    i_trig_val    <= 1'b1;
    @(posedge i_clk);
    while (!(o_trig_rdy && i_trig_val)) @(posedge i_clk);
    i_trig_val <= 1'b0;
    while (!done) begin
      @(posedge i_clk);
      if (o_peaks_val) begin
        done = 1'b1;
      end else begin
        // Tune code must hold at its expected value until accepted
        if (o_tune_val && i_tune_rdy) begin
          check_value("o_ring_tune", int'(o_ring_tune), expected_code(idx, tune_cnt));
          last_code = int'(o_ring_tune);
          tune_cnt++;
          tune_dly = -1;
          i_tune_rdy <= 1'b0;
        end else if (o_tune_val) begin
          if (tune_dly < 0) tune_dly = $random(seed) & 3;
          check_value("o_ring_tune held", int'(o_ring_tune), expected_code(idx, tune_cnt));
          if (tune_dly == 0) i_tune_rdy <= 1'b1;
          else tune_dly--;
        end
        // Commit side returns the power of the last code
        if (o_commit_rdy && i_commit_val) begin
          commit_cnt++;
          cmt_dly = -1;
          i_commit_val <= 1'b0;
        end else if (o_commit_rdy) begin
          if (cmt_dly < 0) cmt_dly = $random(seed) & 3;
          if (cmt_dly == 0) begin
            i_commit_val <= 1'b1;
            i_pwr_commit <= pwr_t'(profile_power(idx, last_code));
          end else begin
            cmt_dly--;
          end
        end
      end
    end
    check_value("tune fire count", tune_cnt, n);
    check_value("commit fire count", commit_cnt, n);
    check_results(1'b0);
    i_peaks_rdy <= 1'b1;
    @(posedge i_clk);
    check_results(1'b1);
    i_peaks_rdy <= 1'b0;
    @(posedge i_clk);
    check_results(1'b0);
    $display("Sweep %0d: start %0d stride %0d, %0d steps, %0d peaks, %0d errors",
             idx, field(idx, 0), field(idx, 2), n, exp_cnt, err_cnt - errs_before);
  endtask

  // ----------------------------------------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------------------------------------
  initial begin
    seed      = 32'h778e;
    err_cnt   = 0;
    check_cnt = 0;
    i_rst         <= 1'b1;
    i_tune_start  <= '0;
    i_tune_end    <= '0;
    i_tune_stride <= '0;
    i_trig_val    <= 1'b0;
    i_peaks_rdy   <= 1'b0;
    i_tune_rdy    <= 1'b0;
    i_commit_val  <= 1'b0;
    i_pwr_commit  <= '0;
    $readmemh("sim/search_cases.txt", case_mem);
    wd_cycles = 0;
    for (int i = 0; i < NUM_CASES; i++) wd_cycles += sweep_len(i) * 12 + 50;
    wd_armed = 1'b1;
    repeat (8) @(posedge i_clk);
    i_rst <= 1'b0;
    @(posedge i_clk);
    // Idle outputs right after reset
    check_value("o_trig_rdy", int'(o_trig_rdy), 1);
    check_value("o_tune_val", int'(o_tune_val), 0);
    check_value("o_commit_rdy", int'(o_commit_rdy), 0);
    check_value("o_peaks_val", int'(o_peaks_val), 0);
    for (int i = 0; i < NUM_CASES; i++) run_sweep(i);
    $display("Summary: %0d sweeps, %0d checks, %0d errors", NUM_CASES, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    wait (wd_armed);
    #(wd_cycles * CLK_NS);
    $display("Watchdog expired before all sweeps finished");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* sim/search_cases.txt */
// start end stride centre1 centre2 height slope period, all hex
// Period 00 gives plain triangles, otherwise the profile repeats
10 50 1 30 30 c8 06 00 // single peak
00 80 1 28 60 b4 05 00 // two peaks
20 60 0 38 3a 64 0a 00 // close peaks, second under hold-off
00 40 0 03 30 50 08 00 // early peak during warm-up
40 40 2 40 40 80 04 00 // no steps
00 a0 0 06 06 3c 0a 0c // comb, more peaks than slots
80 f0 2 b0 d8 f0 03 00 // re-trigger from done
05 ff 4 75 e5 ff 01 00 // coarse stride

/* flist.f */
+incdir+logic
logic/tuner_data_pkg.sv
logic/tuner_ctrl_pkg.sv
logic/search_sequencer.sv
logic/peak_window.sv
logic/peak_store.sv
logic/tuner_search_top.sv
sim/tb_tuner_search.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run from the project root
cd "$(dirname "$0")" || exit 1
LOG=sim_run.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_tuner_search \
  -f flist.f > build.log 2>&1 &&
  ./obj_dir/Vtb_tuner_search > "$LOG" 2>&1 ||
  { cat build.log; echo "Build or run error"; exit 1; }

cat "$LOG"
grep -q "Simulation FAILED" "$LOG" && exit 1
exit 0
